//--- alu8.sv
// -------------------------------------------------------------------------
// 8-bit ALU
// -------------------------------------------------------------------------
`timescale 1ns/10ps

module alu8 (
  input  cpu_isa_pkg::alu_op_e op,
  input  logic                 inherent,
  input  logic [7:0]           lhs,
  input  logic [7:0]           rhs,
  input  cpu_state_pkg::cc_t   cc_in,
  output logic [7:0]           result,
  output cpu_state_pkg::cc_t   cc_out
);

  logic [8:0] sum;
  logic [8:0] diff;
  logic [4:0] half;
  logic [7:0] val;
  logic       keep;
  logic       cin;

  // Carry feeds only ADC and SBC
  assign cin  = ((op == cpu_isa_pkg::ALU_ROL_ADC) || (op == cpu_isa_pkg::ALU_SBC)) ?
                cc_in.c : 1'b0;
  assign sum  = {1'b0, lhs} + {1'b0, rhs} + {8'd0, cin};
  assign diff = {1'b0, lhs} - {1'b0, rhs} - {8'd0, cin};
  assign half = {1'b0, lhs[3:0]} + {1'b0, rhs[3:0]} + {4'd0, cin};

  always_comb begin
    cc_out = cc_in;
    val    = lhs;
    keep   = 1'b0;
    if (inherent) begin
      // Unary on the accumulator
      case (op)
        cpu_isa_pkg::ALU_NEG_SUB: begin
          val      = 8'd0 - lhs;
          cc_out.v = (lhs == 8'h80);
          cc_out.c = (lhs != 8'h00);
        end
        cpu_isa_pkg::ALU_COM: begin
          val      = ~lhs;
          cc_out.v = 1'b0;
          cc_out.c = 1'b1;
        end
        // Right shifts, V untouched
        cpu_isa_pkg::ALU_LSR_AND: begin
          val      = {1'b0, lhs[7:1]};
          cc_out.c = lhs[0];
        end
        cpu_isa_pkg::ALU_ROR_LD: begin
          val      = {cc_in.c, lhs[7:1]};
          cc_out.c = lhs[0];
        end
        cpu_isa_pkg::ALU_ASR: begin
          val      = {lhs[7], lhs[7:1]};
          cc_out.c = lhs[0];
        end
        // Left shifts, V is b7 xor b6 of the input
        cpu_isa_pkg::ALU_ASL_EOR: begin
          val      = {lhs[6:0], 1'b0};
          cc_out.v = lhs[7] ^ lhs[6];
          cc_out.c = lhs[7];
        end
        cpu_isa_pkg::ALU_ROL_ADC: begin
          val      = {lhs[6:0], cc_in.c};
          cc_out.v = lhs[7] ^ lhs[6];
          cc_out.c = lhs[7];
        end
        // DEC and INC leave C alone
        cpu_isa_pkg::ALU_DEC_OR: begin
          val      = lhs - 8'd1;
          cc_out.v = (lhs == 8'h80);
        end
        cpu_isa_pkg::ALU_INC: begin
          val      = lhs + 8'd1;
          cc_out.v = (lhs == 8'h7F);
        end
        cpu_isa_pkg::ALU_TST: cc_out.v = 1'b0;
        cpu_isa_pkg::ALU_CLR: begin
          val      = 8'd0;
          cc_out.v = 1'b0;
          cc_out.c = 1'b0;
        end
        default: val = lhs;
      endcase
    end else begin
      // Accumulator against immediate byte
      case (op)
        cpu_isa_pkg::ALU_NEG_SUB, cpu_isa_pkg::ALU_CMP, cpu_isa_pkg::ALU_SBC: begin
          val      = diff[7:0];
          keep     = (op == cpu_isa_pkg::ALU_CMP);
          cc_out.v = (lhs[7] ^ rhs[7]) & (lhs[7] ^ diff[7]);
          cc_out.c = diff[8];
        end
        cpu_isa_pkg::ALU_LSR_AND, cpu_isa_pkg::ALU_BIT: begin
          val      = lhs & rhs;
          keep     = (op == cpu_isa_pkg::ALU_BIT);
          cc_out.v = 1'b0;
        end
        cpu_isa_pkg::ALU_ROR_LD: begin
          val      = rhs;
          cc_out.v = 1'b0;
        end
        cpu_isa_pkg::ALU_ASL_EOR: begin
          val      = lhs ^ rhs;
          cc_out.v = 1'b0;
        end
        cpu_isa_pkg::ALU_DEC_OR: begin
          val      = lhs | rhs;
          cc_out.v = 1'b0;
        end
        // Only the adds touch H
        cpu_isa_pkg::ALU_ROL_ADC, cpu_isa_pkg::ALU_ADD: begin
          val      = sum[7:0];
          cc_out.h = half[4];
          cc_out.v = ~(lhs[7] ^ rhs[7]) & (lhs[7] ^ sum[7]);
          cc_out.c = sum[8];
        end
        default: val = lhs;
      endcase
    end
    cc_out.n = val[7];
    cc_out.z = (val == 8'd0);
  end

  // Compares and bit tests hand the accumulator back unchanged
  assign result = keep ? lhs : val;

endmodule

//--- bus_wr_if.sv
// -------------------------------------------------------------------------
// Bus and store link
// -------------------------------------------------------------------------
`timescale 1ns/10ps
`include "cpu_cfg.svh"

interface bus_wr_if;

  logic [`CPU_ADDR_W-1:0] fetch_addr;
  logic                   wr_req;
  logic [`CPU_ADDR_W-1:0] wr_addr;
  logic [`CPU_DATA_W-1:0] wr_data;
  // High for the whole write cycle
  logic                   wr_busy;

  modport fetch (output fetch_addr, output wr_req, output wr_addr, input wr_busy);

  modport exec (output wr_data);

  modport port (
    input  fetch_addr,
    input  wr_req,
    input  wr_addr,
    input  wr_data,
    output wr_busy
  );

endinterface

//--- bus_write_port.sv
// -------------------------------------------------------------------------
// Bus write port
// -------------------------------------------------------------------------
`timescale 1ns/10ps
`include "cpu_cfg.svh"

module bus_write_port (
  input  logic                   clk,
  input  logic                   reset_b,
  bus_wr_if.port                 wr,
  output logic [`CPU_ADDR_W-1:0] addr,
  output logic                   data_rw_n,
  output logic [`CPU_DATA_W-1:0] data_out
);

  logic                   busy_q;
  logic [`CPU_ADDR_W-1:0] waddr_q;
  logic [`CPU_DATA_W-1:0] wdata_q;

  // Single write cycle right after the request
  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      busy_q <= 1'b0;
    end else begin
      busy_q <= wr.wr_req;
    end
  end

  // Capture store address and data
  always_ff @(posedge clk) begin
    if (wr.wr_req) begin
      waddr_q <= wr.wr_addr;
      wdata_q <= wr.wr_data;
    end
  end

  assign wr.wr_busy = busy_q;

  // Bus mux, fetch side owns it outside the write cycle
  assign addr      = busy_q ? waddr_q : wr.fetch_addr;
  assign data_rw_n = !busy_q;
  assign data_out  = busy_q ? wdata_q : '0;

  // Fetch must stall through the write cycle
  a_no_back_to_back : assert property (@(posedge clk) disable iff (!reset_b)
    wr.wr_req |-> !wr.wr_busy);

endmodule

//--- compile.f
+incdir+.
cpu_isa_pkg.sv
cpu_state_pkg.sv
inst_if.sv
bus_wr_if.sv
fetch_sequencer.sv
alu8.sv
exec_unit.sv
bus_write_port.sv
cpu_core.sv
tb_cpu_core.sv

//--- cpu_cfg.svh
// -------------------------------------------------------------------------
// CPU core configuration
// -------------------------------------------------------------------------

`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// Bus widths
`define CPU_ADDR_W 16
`define CPU_DATA_W 8

// Vector high byte lives here, low byte one above
`define CPU_RESET_VEC 16'hFFFE

// E, F and I set out of reset
`define CPU_CC_RESET 8'hD0
`define CPU_ACC_RESET 8'h00

`endif

//--- cpu_core.sv
// -------------------------------------------------------------------------
// CPU core top
// -------------------------------------------------------------------------
`timescale 1ns/10ps
`include "cpu_cfg.svh"

module cpu_core (
  input  logic                   clk,
  input  logic                   reset_b,
  input  logic                   halt_b,
  input  logic [`CPU_DATA_W-1:0] din,
  output logic [`CPU_ADDR_W-1:0] addr,
  output logic                   data_rw_n,
  output logic [`CPU_DATA_W-1:0] data_out
);

  inst_if   u_inst ();
  bus_wr_if u_bus ();

  // Input side
  fetch_sequencer u_fetch (
    .clk     (clk),
    .reset_b (reset_b),
    .halt_b  (halt_b),
    .din     (din),
    .ifc     (u_inst.fetch),
    .wr      (u_bus.fetch)
  );

  // Registers and ALU
  exec_unit u_exec (
    .clk     (clk),
    .reset_b (reset_b),
    .ifc     (u_inst.exec),
    .wr      (u_bus.exec)
  );

  // Output side
  bus_write_port u_port (
    .clk       (clk),
    .reset_b   (reset_b),
    .wr        (u_bus.port),
    .addr      (addr),
    .data_rw_n (data_rw_n),
    .data_out  (data_out)
  );

endmodule

//--- cpu_isa_pkg.sv
// -------------------------------------------------------------------------
// Instruction set encodings
// -------------------------------------------------------------------------

package cpu_isa_pkg;

  // Opcode byte split into row and column nibbles
  typedef struct packed {
    logic [3:0] row;
    logic [3:0] col;
  } opcode_nib_t;

  // Decoded whole for stores, by nibble everywhere else
  typedef union packed {
    logic [7:0]  raw;
    opcode_nib_t nib;
  } opcode_t;

  // Column order of the 6809 map
  // Paired names: inherent meaning first, immediate second
  typedef enum logic [3:0] {
    ALU_NEG_SUB = 4'h0,
    ALU_CMP     = 4'h1,
    ALU_SBC     = 4'h2,
    ALU_COM     = 4'h3,
    ALU_LSR_AND = 4'h4,
    ALU_BIT     = 4'h5,
    ALU_ROR_LD  = 4'h6,
    ALU_ASR     = 4'h7,
    ALU_ASL_EOR = 4'h8,
    ALU_ROL_ADC = 4'h9,
    ALU_DEC_OR  = 4'hA,
    ALU_ADD     = 4'hB,
    ALU_INC     = 4'hC,
    ALU_TST     = 4'hD,
    ALU_CLR     = 4'hF
  } alu_op_e;

  // Short branch column codes, others in row 2 fall through
  typedef enum logic [3:0] {
    BR_ALWAYS = 4'h0,
    BR_NEVER  = 4'h1,
    BR_CC     = 4'h4,
    BR_CS     = 4'h5,
    BR_NE     = 4'h6,
    BR_EQ     = 4'h7,
    BR_VC     = 4'h8,
    BR_VS     = 4'h9,
    BR_PL     = 4'hA,
    BR_MI     = 4'hB
  } br_cond_e;

  // Opcode rows
  localparam logic [3:0] ROW_BRANCH = 4'h2;
  localparam logic [3:0] ROW_INH_A  = 4'h4;
  localparam logic [3:0] ROW_INH_B  = 4'h5;
  localparam logic [3:0] ROW_IMM_A  = 4'h8;
  localparam logic [3:0] ROW_IMM_B  = 4'hC;

  // Extended stores
  localparam logic [7:0] OPC_STA_EXT = 8'hB7;
  localparam logic [7:0] OPC_STB_EXT = 8'hF7;

  // Implemented columns, one bit per column
  localparam logic [15:0] INH_COL_MASK = 16'hB7D9;
  localparam logic [15:0] IMM_COL_MASK = 16'h0F77;

endpackage

//--- cpu_state_pkg.sv
// -------------------------------------------------------------------------
// Machine state types
// -------------------------------------------------------------------------

package cpu_state_pkg;

  // One-hot fetch states
  typedef enum logic [5:0] {
    VEC_HI  = 6'b00_0001,
    VEC_LO  = 6'b00_0010,
    OPCODE  = 6'b00_0100,
    OPERAND = 6'b00_1000,
    EXT_LO  = 6'b01_0000,
    HALTED  = 6'b10_0000
  } fetch_state_e;

  // Condition codes, MSB first as on the 6809
  typedef struct packed {
    logic e;  // Entire state saved
    logic f;  // FIRQ mask
    logic h;  // Half carry
    logic i;  // IRQ mask
    logic n;
    logic z;
    logic v;
    logic c;
  } cc_t;

endpackage

//--- exec_unit.sv
// -------------------------------------------------------------------------
// Execution unit
// -------------------------------------------------------------------------
`timescale 1ns/10ps
`include "cpu_cfg.svh"

module exec_unit (
  input  logic   clk,
  input  logic   reset_b,
  inst_if.exec   ifc,
  bus_wr_if.exec wr
);

  logic [`CPU_DATA_W-1:0] a_q;
  logic [`CPU_DATA_W-1:0] b_q;
  cpu_state_pkg::cc_t     cc_q;
  cpu_state_pkg::cc_t     cc_alu;
  logic [`CPU_DATA_W-1:0] acc;
  logic [`CPU_DATA_W-1:0] alu_res;
  logic [3:0]             row;
  logic [3:0]             col;
  logic                   is_inh;
  logic                   is_imm;
  logic                   sel_b;
  logic                   op_valid;
  logic                   a_we;
  logic                   b_we;
  logic                   br_hit;

  assign row = ifc.opcode.nib.row;
  assign col = ifc.opcode.nib.col;

  // -------------------------------------------------------------------------
  // Decode
  // -------------------------------------------------------------------------
  assign is_inh = (row == cpu_isa_pkg::ROW_INH_A) || (row == cpu_isa_pkg::ROW_INH_B);
  assign is_imm = (row == cpu_isa_pkg::ROW_IMM_A) || (row == cpu_isa_pkg::ROW_IMM_B);
  // B for rows 5 and C, and for STB
  assign sel_b  = (row == cpu_isa_pkg::ROW_INH_B) || (row == cpu_isa_pkg::ROW_IMM_B) ||
                  (ifc.opcode.raw == cpu_isa_pkg::OPC_STB_EXT);
  // Unimplemented columns are no-ops
  assign op_valid = (is_inh && cpu_isa_pkg::INH_COL_MASK[col]) ||
                    (is_imm && cpu_isa_pkg::IMM_COL_MASK[col]);

  assign acc = sel_b ? b_q : a_q;

  alu8 u_alu8 (
    .op       (cpu_isa_pkg::alu_op_e'(col)),
    .inherent (is_inh),
    .lhs      (acc),
    .rhs      (ifc.operand),
    .cc_in    (cc_q),
    .result   (alu_res),
    .cc_out   (cc_alu)
  );

  // Write-back on the commit strobe
  assign a_we = ifc.exec_stb && op_valid && !sel_b;
  assign b_we = ifc.exec_stb && op_valid && sel_b;

  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      a_q  <= `CPU_ACC_RESET;
      b_q  <= `CPU_ACC_RESET;
      cc_q <= cpu_state_pkg::cc_t'(`CPU_CC_RESET);
    end else begin
      if (a_we) begin
        a_q <= alu_res;
      end
      if (b_we) begin
        b_q <= alu_res;
      end
      if (a_we || b_we) begin
        cc_q <= cc_alu;
      end
    end
  end

  // -------------------------------------------------------------------------
  // Branch condition on the committed CC
  // -------------------------------------------------------------------------
  always_comb begin
    case (cpu_isa_pkg::br_cond_e'(col))
      cpu_isa_pkg::BR_ALWAYS: br_hit = 1'b1;
      cpu_isa_pkg::BR_NEVER:  br_hit = 1'b0;
      cpu_isa_pkg::BR_CC:     br_hit = !cc_q.c;
      cpu_isa_pkg::BR_CS:     br_hit = cc_q.c;
      cpu_isa_pkg::BR_NE:     br_hit = !cc_q.z;
      cpu_isa_pkg::BR_EQ:     br_hit = cc_q.z;
      cpu_isa_pkg::BR_VC:     br_hit = !cc_q.v;
      cpu_isa_pkg::BR_VS:     br_hit = cc_q.v;
      cpu_isa_pkg::BR_PL:     br_hit = !cc_q.n;
      cpu_isa_pkg::BR_MI:     br_hit = cc_q.n;
      // Signed and unsigned compares not carried
      default:                br_hit = 1'b0;
    endcase
  end

  assign ifc.take_branch = (row == cpu_isa_pkg::ROW_BRANCH) && br_hit;

  // Store data follows the same A/B select
  assign wr.wr_data = acc;

  a_one_acc : assert property (@(posedge clk) disable iff (!reset_b)
    $changed(a_q) |-> $stable(b_q));

endmodule

//--- fetch_sequencer.sv
// -------------------------------------------------------------------------
// Fetch sequencer
// -------------------------------------------------------------------------
`timescale 1ns/10ps
`include "cpu_cfg.svh"

module fetch_sequencer (
  input  logic                   clk,
  input  logic                   reset_b,
  input  logic                   halt_b,
  input  logic [`CPU_DATA_W-1:0] din,
  inst_if.fetch                  ifc,
  bus_wr_if.fetch                wr
);

  localparam logic [`CPU_ADDR_W-1:0] VEC_LO_ADDR = `CPU_RESET_VEC + 1'b1;

  cpu_state_pkg::fetch_state_e state_q;
  cpu_state_pkg::fetch_state_e state_d;
  cpu_isa_pkg::opcode_t        opc_q;
  cpu_isa_pkg::opcode_t        opc_in;
  logic [`CPU_ADDR_W-1:0]      pc_q;
  logic [`CPU_ADDR_W-1:0]      pc_d;
  logic [`CPU_DATA_W-1:0]      ext_hi_q;
  logic                        inh_stb_q;

  logic st_vec_hi;
  logic st_vec_lo;
  logic st_opcode;
  logic st_operand;
  logic st_ext_lo;
  logic advance;
  logic opc_take;
  logic in_two;
  logic in_ext;
  logic q_ext;
  logic q_branch;

  assign st_vec_hi  = (state_q == cpu_state_pkg::VEC_HI);
  assign st_vec_lo  = (state_q == cpu_state_pkg::VEC_LO);
  assign st_opcode  = (state_q == cpu_state_pkg::OPCODE);
  assign st_operand = (state_q == cpu_state_pkg::OPERAND);
  assign st_ext_lo  = (state_q == cpu_state_pkg::EXT_LO);

  // Everything freezes while the write port owns the bus
  assign advance  = !wr.wr_busy;
  assign opc_take = st_opcode && halt_b && advance;

  // -------------------------------------------------------------------------
  // Length classifier, straight off the data bus
  // -------------------------------------------------------------------------
  assign opc_in.raw = din;
  assign in_ext = (opc_in.raw == cpu_isa_pkg::OPC_STA_EXT) ||
                  (opc_in.raw == cpu_isa_pkg::OPC_STB_EXT);
  // Branches and implemented immediates take one operand byte
  assign in_two = (opc_in.nib.row == cpu_isa_pkg::ROW_BRANCH) ||
                  (((opc_in.nib.row == cpu_isa_pkg::ROW_IMM_A) ||
                    (opc_in.nib.row == cpu_isa_pkg::ROW_IMM_B)) &&
                   cpu_isa_pkg::IMM_COL_MASK[opc_in.nib.col]);

  // Same questions about the held opcode
  assign q_ext    = (opc_q.raw == cpu_isa_pkg::OPC_STA_EXT) ||
                    (opc_q.raw == cpu_isa_pkg::OPC_STB_EXT);
  assign q_branch = (opc_q.nib.row == cpu_isa_pkg::ROW_BRANCH);

  // Next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      cpu_state_pkg::VEC_HI: state_d = cpu_state_pkg::VEC_LO;
      cpu_state_pkg::VEC_LO: state_d = cpu_state_pkg::OPCODE;
      cpu_state_pkg::OPCODE: begin
        // Halt only at an instruction boundary
        if (!halt_b) begin
          state_d = cpu_state_pkg::HALTED;
        end else if (in_two || in_ext) begin
          state_d = cpu_state_pkg::OPERAND;
        end
      end
      cpu_state_pkg::OPERAND: begin
        state_d = q_ext ? cpu_state_pkg::EXT_LO : cpu_state_pkg::OPCODE;
      end
      cpu_state_pkg::EXT_LO: state_d = cpu_state_pkg::OPCODE;
      cpu_state_pkg::HALTED: begin
        if (halt_b) begin
          state_d = cpu_state_pkg::OPCODE;
        end
      end
      default: state_d = cpu_state_pkg::VEC_HI;
    endcase
  end

  // -------------------------------------------------------------------------
  // Program counter
  // -------------------------------------------------------------------------
  always_comb begin
    pc_d = pc_q + 1'b1;
    case (state_q)
      // Vector is big-endian
      cpu_state_pkg::VEC_HI: pc_d = {din, pc_q[`CPU_DATA_W-1:0]};
      cpu_state_pkg::VEC_LO: pc_d = {pc_q[`CPU_ADDR_W-1:`CPU_DATA_W], din};
      cpu_state_pkg::OPCODE: begin
        if (!halt_b) begin
          pc_d = pc_q;
        end
      end
      cpu_state_pkg::OPERAND: begin
        // pc sits on the offset, so target is pc+1+offset
        if (q_branch && ifc.take_branch) begin
          pc_d = pc_q + 1'b1 +
                 {{(`CPU_ADDR_W-`CPU_DATA_W){din[`CPU_DATA_W-1]}}, din};
        end
      end
      cpu_state_pkg::HALTED: pc_d = pc_q;
      default: pc_d = pc_q + 1'b1;
    endcase
  end

  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      state_q   <= cpu_state_pkg::VEC_HI;
      pc_q      <= '0;
      inh_stb_q <= 1'b0;
    end else begin
      if (advance) begin
        state_q <= state_d;
        pc_q    <= pc_d;
      end
      // One-byte ops commit in the following cycle
      inh_stb_q <= opc_take && !in_two && !in_ext;
    end
  end

  // Opcode and extended high byte
  always_ff @(posedge clk) begin
    if (opc_take) begin
      opc_q <= opc_in;
    end
    if (st_operand && q_ext) begin
      ext_hi_q <= din;
    end
  end

  assign ifc.opcode   = opc_q;
  assign ifc.operand  = din;
  assign ifc.exec_stb = inh_stb_q || (st_operand && !q_ext) || st_ext_lo;

  assign wr.fetch_addr = st_vec_hi ? `CPU_RESET_VEC :
                         st_vec_lo ? VEC_LO_ADDR : pc_q;
  assign wr.wr_req     = st_ext_lo;
  assign wr.wr_addr    = {ext_hi_q, din};

  a_state_onehot : assert property (@(posedge clk) disable iff (!reset_b)
    $onehot(state_q));

  // Deferred commit must not leak into the vector load
  a_no_stb_in_vec : assert property (@(posedge clk) disable iff (!reset_b)
    ifc.exec_stb |-> !(st_vec_hi || st_vec_lo));

endmodule

//--- inst_if.sv
// -------------------------------------------------------------------------
// Fetch to execute link
// -------------------------------------------------------------------------
`timescale 1ns/10ps
`include "cpu_cfg.svh"

interface inst_if;

  // Registered opcode of the instruction in flight
  cpu_isa_pkg::opcode_t   opcode;
  // Raw data bus, valid in the last byte
  logic [`CPU_DATA_W-1:0] operand;
  // Commit strobe, one cycle
  logic                   exec_stb;
  // Branch decision back to fetch
  logic                   take_branch;

  modport fetch (
    output opcode,
    output operand,
    output exec_stb,
    input  take_branch
  );

  modport exec (
    input  opcode,
    input  operand,
    input  exec_stb,
    output take_branch
  );

endinterface

//--- run_sim.sh
#!/bin/sh
# Build the CPU core testbench with Verilator, run it and look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f compile.f --top-module tb_cpu_core -o tb_cpu_core

out=$(./obj_dir/tb_cpu_core || true)
echo "$out"
echo "$out" | grep -qx "TEST OK"

//--- tb_program.svh
// -------------------------------------------------------------------------
// Program builder and reference model
// -------------------------------------------------------------------------

// Column pools, one nibble per entry
localparam logic [39:0] IMM_COLS = 40'h0124_5689AB;
localparam logic [43:0] INH_COLS = 44'h034_6789_ACDF;
// 2 and C never branch here
localparam logic [47:0] BR_COLS  = 48'h0124_5678_9ABC;
// One-byte ops that a forward branch may skip
localparam logic [31:0] SKIP_OPS = 32'h4C5A_1243;

int unsigned        lcg_state = 32'd8;
logic [15:0]        wp;
logic [15:0]        end_pc;
int                 n_ops = 0;
int                 n_taken = 0;
int                 n_not_taken = 0;
int                 n_writes = 0;
int                 n_halts = 0;

// Model machine state
logic [7:0]         ma;
logic [7:0]         mb;
cpu_state_pkg::cc_t mcc;
logic [15:0]        mpc;
int                 ncyc;

function automatic logic [7:0] next_rand();
  lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
  return lcg_state[23:16];
endfunction

function automatic logic [3:0] imm_col();
  int k;
  k = int'(next_rand()) % 10;
  return IMM_COLS[4*k +: 4];
endfunction

function automatic logic [3:0] inh_col();
  int k;
  k = int'(next_rand()) % 11;
  return INH_COLS[4*k +: 4];
endfunction

function automatic logic [3:0] br_col();
  int k;
  k = int'(next_rand()) % 12;
  return BR_COLS[4*k +: 4];
endfunction

function automatic logic halt_low(input int c);
  return (c >= HALT_START) && (c < HALT_START + HALT_LEN);
endfunction

// Background pattern from the full address
task automatic fill_memory();
  logic [15:0] a;
  for (int i = 0; i < 65536; i++) begin
    a = i[15:0];
    mem[a] = a[15:8] ^ a[7:0] ^ 8'hA5;
  end
endtask

task automatic put_byte(input logic [7:0] b);
  mem[wp] = b;
  wp = wp + 16'd1;
endtask

// -------------------------------------------------------------------------
// Random program at the reset vector, ends in a BRA to itself
// -------------------------------------------------------------------------
task automatic build_program(input int groups);
  int         g;
  int         k;
  logic [7:0] r;
  logic [3:0] row_m;
  logic [3:0] row_i;
  wp = {8'h04, next_rand()};
  mem[`CPU_RESET_VEC] = wp[15:8];
  mem[`CPU_RESET_VEC + 16'd1] = wp[7:0];
  for (g = 0; g < groups; g++) begin
    r = next_rand();
    row_m = r[7] ? cpu_isa_pkg::ROW_IMM_B : cpu_isa_pkg::ROW_IMM_A;
    row_i = r[6] ? cpu_isa_pkg::ROW_INH_B : cpu_isa_pkg::ROW_INH_A;
    case (r[2:0])
      3'd0, 3'd1: begin
        put_byte({row_m, imm_col()});
        put_byte(next_rand());
        n_ops++;
      end
      3'd2, 3'd3: begin
        put_byte({row_i, inh_col()});
        n_ops++;
      end
      // Store into 6xxx, clear of the code
      3'd4: begin
        put_byte(r[5] ? cpu_isa_pkg::OPC_STB_EXT : cpu_isa_pkg::OPC_STA_EXT);
        put_byte({4'h6, r[6:3]});
        put_byte(next_rand());
        n_ops++;
      end
      3'd5: begin
        put_byte(8'h12);
        n_ops++;
      end
      default: begin
        // CMP, TST or ADD, then a short forward branch
        k = int'(next_rand()) % 3;
        if (k == 0) begin
          put_byte({row_m, 4'h1});
          put_byte(next_rand());
        end else if (k == 1) begin
          put_byte({row_i, 4'hD});
        end else begin
          put_byte({row_m, 4'hB});
          put_byte(next_rand());
        end
        put_byte({cpu_isa_pkg::ROW_BRANCH, br_col()});
        k = int'(next_rand()) % 4;
        put_byte(k[7:0]);
        for (int j = 0; j < k; j++) begin
          put_byte(SKIP_OPS[8*(int'(next_rand()) % 4) +: 8]);
        end
        n_ops = n_ops + 2 + k;
      end
    endcase
  end
  end_pc = wp;
  put_byte(8'h20);
  put_byte(8'hFE);
  n_ops++;
endtask

// -------------------------------------------------------------------------
// Instruction rules
// -------------------------------------------------------------------------
function automatic logic imm_known(input logic [3:0] col);
  case (col)
    4'h0, 4'h1, 4'h2, 4'h4, 4'h5, 4'h6, 4'h8, 4'h9, 4'hA, 4'hB: return 1'b1;
    default: return 1'b0;
  endcase
endfunction

function automatic logic branch_taken(input logic [3:0] col);
  case (col)
    4'h0: return 1'b1;
    4'h4: return !mcc.c;
    4'h5: return mcc.c;
    4'h6: return !mcc.z;
    4'h7: return mcc.z;
    4'h8: return !mcc.v;
    4'h9: return mcc.v;
    4'hA: return !mcc.n;
    4'hB: return mcc.n;
    default: return 1'b0;
  endcase
endfunction

// Unary accumulator ops
task automatic apply_inh(input logic [3:0] col, inout logic [7:0] r);
  logic [7:0] x;
  logic       known;
  x = r;
  known = 1'b1;
  case (col)
    4'h0: begin
      r = 8'h00 - x;
      mcc.v = (x == 8'h80);
      mcc.c = (x != 8'h00);
    end
    4'h3: begin
      r = ~x;
      mcc.v = 1'b0;
      mcc.c = 1'b1;
    end
    4'h4: begin
      r = x >> 1;
      mcc.c = x[0];
    end
    4'h6: begin
      r = {mcc.c, x[7:1]};
      mcc.c = x[0];
    end
    4'h7: begin
      r = {x[7], x[7:1]};
      mcc.c = x[0];
    end
    4'h8: begin
      r = x << 1;
      mcc.v = x[7] ^ x[6];
      mcc.c = x[7];
    end
    4'h9: begin
      r = {x[6:0], mcc.c};
      mcc.v = x[7] ^ x[6];
      mcc.c = x[7];
    end
    4'hA: begin
      r = x - 8'd1;
      mcc.v = (x == 8'h80);
    end
    4'hC: begin
      r = x + 8'd1;
      mcc.v = (x == 8'h7F);
    end
    4'hD: mcc.v = 1'b0;
    4'hF: begin
      r = 8'h00;
      mcc.v = 1'b0;
      mcc.c = 1'b0;
    end
    default: known = 1'b0;
  endcase
  if (known) begin
    mcc.n = r[7];
    mcc.z = (r == 8'h00);
  end
endtask

// Accumulator against the immediate byte, signed range decides V
task automatic apply_imm(input logic [3:0] col, input logic [7:0] m, inout logic [7:0] r);
  int         u;
  int         s;
  int         cin;
  logic [7:0] res;
  cin = ((col == 4'h2) || (col == 4'h9)) ? int'(mcc.c) : 0;
  res = r;
  case (col)
    4'h0, 4'h1, 4'h2: begin
      u = int'(r) - int'(m) - cin;
      s = int'($signed(r)) - int'($signed(m)) - cin;
      res = u[7:0];
      mcc.c = (u < 0);
      mcc.v = (s < -128) || (s > 127);
    end
    4'h9, 4'hB: begin
      u = int'(r) + int'(m) + cin;
      s = int'($signed(r)) + int'($signed(m)) + cin;
      res = u[7:0];
      mcc.h = (int'(r[3:0]) + int'(m[3:0]) + cin) > 15;
      mcc.c = (u > 255);
      mcc.v = (s < -128) || (s > 127);
    end
    4'h4, 4'h5: res = r & m;
    4'h6: res = m;
    4'h8: res = r ^ m;
    4'hA: res = r | m;
    default: res = r;
  endcase
  if (!((col == 4'h0) || (col == 4'h1) || (col == 4'h2) || (col == 4'h9) || (col == 4'hB))) begin
    mcc.v = 1'b0;
  end
  mcc.n = res[7];
  mcc.z = (res == 8'h00);
  // CMP and BIT leave the register alone
  if ((col != 4'h1) && (col != 4'h5)) begin
    r = res;
  end
endtask

// -------------------------------------------------------------------------
// Cycle trace
// -------------------------------------------------------------------------
task automatic emit(input logic [15:0] a, input logic rw, input logic [7:0] d, input logic h);
  exp_addr[ncyc] = a;
  exp_rw[ncyc]   = rw;
  exp_dout[ncyc] = d;
  exp_halt[ncyc] = h;
  ncyc++;
endtask

task automatic model_step();
  cpu_isa_pkg::opcode_t op;
  logic [7:0]           b1;
  logic [7:0]           b2;
  logic                 taken;
  // Halt only bites at the opcode cycle, one extra cycle on release
  while (halt_low(ncyc)) begin
    emit(mpc, 1'b1, 8'h00, 1'b0);
    while (halt_low(ncyc)) begin
      emit(mpc, 1'b1, 8'h00, 1'b1);
    end
    emit(mpc, 1'b1, 8'h00, 1'b1);
    n_halts++;
  end
  op.raw = mem[mpc];
  b1 = mem[mpc + 16'd1];
  b2 = mem[mpc + 16'd2];
  emit(mpc, 1'b1, 8'h00, 1'b0);
  if ((op.raw == cpu_isa_pkg::OPC_STA_EXT) || (op.raw == cpu_isa_pkg::OPC_STB_EXT)) begin
    emit(mpc + 16'd1, 1'b1, 8'h00, 1'b0);
    emit(mpc + 16'd2, 1'b1, 8'h00, 1'b0);
    emit({b1, b2}, 1'b0, (op.raw == cpu_isa_pkg::OPC_STA_EXT) ? ma : mb, 1'b0);
    mpc = mpc + 16'd3;
    n_writes++;
  end else if (op.nib.row == cpu_isa_pkg::ROW_BRANCH) begin
    emit(mpc + 16'd1, 1'b1, 8'h00, 1'b0);
    taken = branch_taken(op.nib.col);
    if (mpc != end_pc) begin
      if (taken) begin
        n_taken++;
      end else begin
        n_not_taken++;
      end
    end
    mpc = mpc + 16'd2 + (taken ? {{8{b1[7]}}, b1} : 16'd0);
  end else if ((op.nib.row == cpu_isa_pkg::ROW_IMM_A) && imm_known(op.nib.col)) begin
    emit(mpc + 16'd1, 1'b1, 8'h00, 1'b0);
    apply_imm(op.nib.col, b1, ma);
    mpc = mpc + 16'd2;
  end else if ((op.nib.row == cpu_isa_pkg::ROW_IMM_B) && imm_known(op.nib.col)) begin
    emit(mpc + 16'd1, 1'b1, 8'h00, 1'b0);
    apply_imm(op.nib.col, b1, mb);
    mpc = mpc + 16'd2;
  end else begin
    if (op.nib.row == cpu_isa_pkg::ROW_INH_A) begin
      apply_inh(op.nib.col, ma);
    end else if (op.nib.row == cpu_isa_pkg::ROW_INH_B) begin
      apply_inh(op.nib.col, mb);
    end
    mpc = mpc + 16'd1;
  end
endtask

task automatic run_model();
  ma   = `CPU_ACC_RESET;
  mb   = `CPU_ACC_RESET;
  mcc  = cpu_state_pkg::cc_t'(`CPU_CC_RESET);
  ncyc = 0;
  emit(`CPU_RESET_VEC, 1'b1, 8'h00, 1'b0);
  emit(`CPU_RESET_VEC + 16'd1, 1'b1, 8'h00, 1'b0);
  mpc = {mem[`CPU_RESET_VEC], mem[`CPU_RESET_VEC + 16'd1]};
  while ((mpc != end_pc) && (ncyc < MAX_CYC - 64)) begin
    model_step();
  end
  // A few turns of the closing loop
  repeat (8) begin
    model_step();
  end
  trace_len = ncyc;
endtask

//--- tb_cpu_core.sv
// -------------------------------------------------------------------------
// CPU core testbench
// -------------------------------------------------------------------------
`timescale 1ns/10ps
`include "cpu_cfg.svh"

module tb_cpu_core;

  localparam int MAX_CYC    = 4096;
  localparam int GROUPS     = 90;
  localparam int HALT_START = 97;
  localparam int HALT_LEN   = 9;

  logic                   clk = 1'b0;
  logic                   reset_b = 1'b0;
  logic                   halt_b = 1'b1;
  logic [`CPU_DATA_W-1:0] din;
  logic [`CPU_ADDR_W-1:0] addr;
  logic                   data_rw_n;
  logic [`CPU_DATA_W-1:0] data_out;

  // Memory and the expected bus trace with one entry per cycle after reset
  logic [7:0]  mem      [0:65535];
  logic [15:0] exp_addr [0:MAX_CYC-1];
  logic        exp_rw   [0:MAX_CYC-1];
  logic [7:0]  exp_dout [0:MAX_CYC-1];
  logic        exp_halt [0:MAX_CYC-1];

  int          cyc = 0;
  int          trace_len = 0;
  logic        run = 1'b0;
  logic        active;
  logic [15:0] want_addr;
  logic        want_rw;
  logic [7:0]  want_dout;
  logic        want_halt;

  `include "tb_program.svh"

  cpu_core dut0 (
    .clk       (clk),
    .reset_b   (reset_b),
    .halt_b    (halt_b),
    .din       (din),
    .addr      (addr),
    .data_rw_n (data_rw_n),
    .data_out  (data_out)
  );

  always #2 clk = ~clk;

  // Combinational read
  assign din = mem[addr];

  always @(posedge clk) begin
    if (run) begin
      cyc <= cyc + 1;
    end
  end

  // Halt window driven just after the edge
  always @(posedge clk) begin
    #1 halt_b = !halt_low(cyc);
  end

  assign active    = run && (cyc < trace_len);
  assign want_addr = exp_addr[cyc[11:0]];
  assign want_rw   = exp_rw[cyc[11:0]];
  assign want_dout = exp_dout[cyc[11:0]];
  assign want_halt = exp_halt[cyc[11:0]];

  task automatic report_fail(input string msg);
    $display("[FAIL] %0t %s", $time, msg);
    $display("TEST FAILED");
    $fatal(1, "stopped at the first mismatch");
  endtask

  // -------------------------------------------------------------------------
  // Checks against the model trace
  // -------------------------------------------------------------------------
  a_addr : assert property (@(posedge clk)
    active |-> (addr == want_addr))
    else report_fail($sformatf("cycle %0d addr %h, model %h",
                               $sampled(cyc), $sampled(addr), $sampled(want_addr)));

  a_rw : assert property (@(posedge clk)
    active |-> (data_rw_n == want_rw))
    else report_fail($sformatf("cycle %0d data_rw_n %b, model %b",
                               $sampled(cyc), $sampled(data_rw_n), $sampled(want_rw)));

  a_dout : assert property (@(posedge clk)
    active |-> (data_out == want_dout))
    else report_fail($sformatf("cycle %0d data_out %h, model %h",
                               $sampled(cyc), $sampled(data_out), $sampled(want_dout)));

  // Parked bus while halted
  a_halt_hold : assert property (@(posedge clk)
    (active && want_halt) |-> (data_rw_n && $stable(addr)))
    else report_fail($sformatf("cycle %0d bus moved while halted, addr %h",
                               $sampled(cyc), $sampled(addr)));

  initial begin
    fill_memory();
    build_program(GROUPS);
    run_model();
    repeat (16) @(posedge clk);
    #1;
    reset_b = 1'b1;
    run = 1'b1;
    while (cyc < trace_len) begin
      @(posedge clk);
      #1;
    end
    if ((n_taken > 0) && (n_not_taken > 0) && (n_writes > 0) && (n_halts > 0)) begin
      $display("TEST OK");
      $finish;
    end else begin
      $display("Program missed a taken branch, an untaken branch, a store or the halt");
      $display("TEST FAILED");
      $fatal(1, "stimulus incomplete");
    end
  end

  // Watchdog allows four cycles per instruction plus slack
  initial begin
    wait (n_ops > 0);
    repeat (16 + n_ops * 4 + 200) @(posedge clk);
    $display("Watchdog expired before the program trace was complete");
    $display("TEST FAILED");
    $fatal(1, "watchdog timeout");
  end

endmodule
